// ==== source/exec_macros.svh ====
// Width macros for the execute stage: data, virtual, physical and exception code
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data and address width
`define XLEN 64

// Virtual address width, upper bits must repeat bit VLEN-1
`define VLEN 39

// Physical address width from the MMU
`define PLEN 56

// Exception code width
`define EXC_W 6

`endif

// ==== source/exec_pkg.sv ====
// Package exec_pkg: privilege mode, memory access, result select and exception code types
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    // Privilege modes, H mode unused
    typedef enum logic [1:0] {
        U = 2'd0,
        S = 2'd1,
        M = 2'd3
    } mode_t;

    // Size and direction of a data access
    typedef enum logic [3:0] {
        NONE,
        BYTE_READ,
        HWORD_READ,
        WORD_READ,
        DWORD_READ,
        BYTE_WRITE,
        HWORD_WRITE,
        WORD_WRITE,
        DWORD_WRITE
    } mem_access_t;

    // Source of the stage result
    typedef enum logic [2:0] {
        ADD,
        SC_RESULT,
        MEMORY,
        INTERNAL_REGISTER,
        RETURN_ADDRESS
    } result_select_t;

    // Cause codes, interrupts share the space with exceptions
    typedef enum logic [`EXC_W-1:0] {
        I_ADDR_MISALIGNED = 0,
        I_ILLEGAL         = 2,
        BREAKPOINT        = 3,
        L_ADDR_MISALIGNED = 4,
        S_INT_TIMER       = 5,
        S_ADDR_MISALIGNED = 6,
        M_INT_TIMER       = 7,
        U_CALL            = 8,  // S and M calls follow by mode
        S_INT_EXT         = 9,
        M_INT_EXT         = 11,
        L_PAGE_FAULT      = 13,
        S_PAGE_FAULT      = 15,
        L_TLB_MISS        = 24,
        S_TLB_MISS        = 25,
        S_TLB_NOT_DIRTY   = 26
    } exc_code_t;

endpackage

`default_nettype wire

// ==== source/interrupt_gate.sv ====
// Module interrupt_gate: first-cycle register, conditioned interrupts, WFI wake
`timescale 1ns/100ps
`default_nettype none

module interrupt_gate (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            suppress_interrupts,
    input  logic            m_tie,
    input  logic            s_tie,
    input  logic            m_eie,
    input  logic            s_eie,
    input  logic            m_timer,
    input  logic            s_timer,
    input  logic            m_interrupt,
    input  logic            s_interrupt,
    input  exec_pkg::mode_t current_mode,
    output logic            m_timer_c,
    output logic            s_timer_c,
    output logic            m_int_c,
    output logic            s_int_c,
    output logic            wake
);
    import exec_pkg::*;

    logic stalled;  // High after the first cycle of an instruction
    logic open_m;   // Gate common to all four lines
    logic open_s;   // Supervisor lines also need mode S or U

    always_ff @(posedge clock) begin
        if (!rst_n)
            stalled <= 1'b0;
        else
            stalled <= stall;
    end

    assign open_m = !suppress_interrupts && !stalled;
    assign open_s = open_m && (current_mode <= S);

    assign m_timer_c = open_m && m_tie && m_timer;
    assign s_timer_c = open_s && s_tie && s_timer;
    assign m_int_c   = open_m && m_eie && m_interrupt;
    assign s_int_c   = open_s && s_eie && s_interrupt;

    // Raw lines, enables and suppression ignored
    assign wake = m_timer || s_timer || m_interrupt || s_interrupt;

    // Encoding 2 has no mode behind it
    a_mode_legal: assert property (@(posedge clock) disable iff (!rst_n)
        current_mode == U || current_mode == S || current_mode == M);

endmodule

`default_nettype wire

// ==== source/exception_priority.sv ====
// Module exception_priority: pending flag, interrupt flag and prioritized cause code
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module exception_priority (
    input  logic                instruction_addr_misaligned,
    input  logic                instruction_illegal,
    input  logic                e_call,
    input  logic                e_break,
    input  logic                m_timer_c,
    input  logic                s_timer_c,
    input  logic                m_int_c,
    input  logic                s_int_c,
    input  logic                load_misaligned,
    input  logic                store_misaligned,
    input  logic                load_page_fault,
    input  logic                store_page_fault,
    input  logic                tlb_miss,
    input  logic                store_access,
    input  logic                mmu_fault_dns,
    input  exec_pkg::mode_t     current_mode,
    output logic                exception_pending,
    output logic                interrupt_exception,
    output exec_pkg::exc_code_t exception_code
);
    import exec_pkg::*;

    logic any_interrupt;

    assign any_interrupt = m_int_c || s_int_c || m_timer_c || s_timer_c;

    assign exception_pending = any_interrupt
        || instruction_addr_misaligned || instruction_illegal || e_call || e_break
        || load_misaligned || store_misaligned
        || load_page_fault || store_page_fault || tlb_miss;

    assign interrupt_exception = any_interrupt;

    // Highest priority first
    always_comb begin
        exception_code = I_ADDR_MISALIGNED;  // Don't care when nothing pending
        if (m_int_c)
            exception_code = M_INT_EXT;
        else if (s_int_c)
            exception_code = S_INT_EXT;
        else if (m_timer_c)
            exception_code = M_INT_TIMER;
        else if (s_timer_c)
            exception_code = S_INT_TIMER;
        else if (instruction_addr_misaligned)
            exception_code = I_ADDR_MISALIGNED;
        else if (instruction_illegal)
            exception_code = I_ILLEGAL;
        else if (e_break)
            exception_code = BREAKPOINT;
        else if (load_misaligned)
            exception_code = L_ADDR_MISALIGNED;
        else if (store_misaligned)
            exception_code = S_ADDR_MISALIGNED;
        else if (e_call)
            exception_code = exc_code_t'(U_CALL + current_mode);  // 8, 9 or 11
        else if (load_page_fault)
            exception_code = L_PAGE_FAULT;
        else if (store_page_fault)
            exception_code = mmu_fault_dns ? S_TLB_NOT_DIRTY : S_PAGE_FAULT;
        else if (tlb_miss)
            exception_code = store_access ? S_TLB_MISS : L_TLB_MISS;
    end

endmodule

`default_nettype wire

// ==== source/memory_access_unit.sv ====
// Module memory_access_unit: address, MMU bits, faults, LR/SC reservation, load extension
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module memory_access_unit (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic [`XLEN-1:0]      a,
    input  logic [`XLEN-1:0]      b,
    input  logic [`XLEN-1:0]      mem_data_in,
    input  exec_pkg::mem_access_t memory_access,
    input  logic                  is_memory_op,
    input  logic                  is_lr,
    input  logic                  is_sc,
    input  logic                  is_signed_memory_op,
    input  logic                  exception_pending,
    input  logic                  mmu_match,
    input  logic                  mmu_fault,
    input  logic                  mem_ack,
    input  logic [`PLEN-1:0]      mmu_paddr,
    output logic [`XLEN-1:0]      eff_addr,
    output logic [`XLEN-1:0]      memory_result,
    output logic [`XLEN-1:0]      mem_data_out,
    output logic [`VLEN-1:0]      mmu_vaddr,
    output logic                  mmu_access_r,
    output logic                  mmu_access_w,
    output logic                  store_access,
    output logic                  mem_cycle,
    output logic                  mem_done,
    output logic                  reserved,
    output logic                  load_misaligned,
    output logic                  store_misaligned,
    output logic                  load_page_fault,
    output logic                  store_page_fault,
    output logic                  tlb_miss,
    output logic [`PLEN-1:0]      mem_paddr,
    output exec_pkg::mem_access_t mem_access
);
    import exec_pkg::*;

    logic vaddr_fault;  // Address outside the sign-extended VLEN range
    logic misaligned;   // Low address bits set for the access size
    logic page_fault;
    logic sx;           // Sign bit for load extension

    assign eff_addr     = a + b;
    assign mmu_vaddr    = eff_addr[`VLEN-1:0];
    assign vaddr_fault  = eff_addr[`XLEN-1:`VLEN] != {(`XLEN-`VLEN){eff_addr[`VLEN-1]}};
    assign store_access = mmu_access_w;

    // Direction bits to the MMU
    always_comb begin
        mmu_access_r = 1'b0;
        mmu_access_w = 1'b0;
        case (memory_access)
            BYTE_READ, HWORD_READ, WORD_READ, DWORD_READ:     mmu_access_r = 1'b1;
            BYTE_WRITE, HWORD_WRITE, WORD_WRITE, DWORD_WRITE: mmu_access_w = 1'b1;
            default: ;
        endcase
    end

    // Byte accesses never misalign
    always_comb begin
        case (memory_access)
            HWORD_READ, HWORD_WRITE: misaligned = eff_addr[0];
            WORD_READ, WORD_WRITE:   misaligned = |eff_addr[1:0];
            DWORD_READ, DWORD_WRITE: misaligned = |eff_addr[2:0];
            default:                 misaligned = 1'b0;
        endcase
    end

    assign page_fault = vaddr_fault || (mmu_match && mmu_fault);

    assign load_misaligned  = is_memory_op && mmu_access_r && misaligned;
    assign store_misaligned = is_memory_op && mmu_access_w && misaligned;
    assign load_page_fault  = is_memory_op && mmu_access_r && page_fault;
    assign store_page_fault = is_memory_op && mmu_access_w && page_fault;
    assign tlb_miss         = is_memory_op && !mmu_match;

    // LR/SC reservation, any other completed access drops it
    always_ff @(posedge clock) begin
        if (!rst_n)
            reserved <= 1'b0;
        else if (exception_pending)
            reserved <= 1'b0;
        else if (mem_done && is_lr)
            reserved <= 1'b1;
        else if (mem_done && is_memory_op)
            reserved <= 1'b0;
    end

    // Failed SC finishes at once
    assign mem_done  = mem_ack || (is_sc && !reserved);
    assign mem_cycle = is_memory_op && !exception_pending && (!is_sc || reserved);

    assign mem_paddr    = mmu_paddr;
    assign mem_access   = memory_access;
    assign mem_data_out = b;

    // Memory returns data right-aligned
    assign sx = is_signed_memory_op;
    always_comb begin
        case (memory_access)
            BYTE_READ:
                memory_result = {{(`XLEN-8){sx && mem_data_in[7]}}, mem_data_in[7:0]};
            HWORD_READ:
                memory_result = {{(`XLEN-16){sx && mem_data_in[15]}}, mem_data_in[15:0]};
            WORD_READ:
                memory_result = {{(`XLEN-32){sx && mem_data_in[31]}}, mem_data_in[31:0]};
            default:
                memory_result = mem_data_in;  // Dword, nothing to extend
        endcase
    end

    // Ack is a single-cycle pulse
    a_ack_pulse: assert property (@(posedge clock) disable iff (!rst_n)
        mem_ack |=> !mem_ack);

endmodule

`default_nettype wire

// ==== source/writeback_redirect.sv ====
// Module writeback_redirect: result mux, register write, stall and redirect
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module writeback_redirect (
    input  exec_pkg::result_select_t result_select,
    input  logic [`XLEN-1:0]         eff_addr,
    input  logic [`XLEN-1:0]         memory_result,
    input  logic [`XLEN-1:0]         ireg_out,
    input  logic [`XLEN-1:1]         decode_instruction_vaddr,
    input  logic [`XLEN-1:2]         exception_vaddr,
    input  logic                     reserved,
    input  logic                     mem_done,
    input  logic                     is_memory_op,
    input  logic                     wait_for_interrupt,
    input  logic                     wake,
    input  logic                     save_result_to_gpr,
    input  logic                     exception_pending,
    input  logic                     is_branch,
    input  logic                     branch_taken,
    input  logic [4:0]               rd_num,
    output logic [`XLEN-1:0]         execute_result,
    output logic [`XLEN-1:0]         rd_value,
    output logic [4:0]               rd,
    output logic                     rd_write,
    output logic                     stall,
    output logic                     redirect,
    output logic [`XLEN-1:1]         redirect_vaddr
);
    import exec_pkg::*;

    logic [`XLEN-1:0] result;

    always_comb begin
        case (result_select)
            ADD:               result = eff_addr;
            SC_RESULT:         result = {{(`XLEN-1){1'b0}}, !reserved};  // 0 on success
            MEMORY:            result = memory_result;
            INTERNAL_REGISTER: result = ireg_out;
            RETURN_ADDRESS:    result = {decode_instruction_vaddr, 1'b0};
            default:           result = eff_addr;
        endcase
    end

    assign execute_result = result;
    assign rd_value       = result;
    assign rd             = rd_num;
    assign rd_write       = save_result_to_gpr && !exception_pending;

    // An exception ends the instruction at once
    assign stall = !exception_pending && (
        (is_memory_op && !mem_done) ||
        (wait_for_interrupt && !wake));

    assign redirect = exception_pending || (is_branch && branch_taken);

    // Vector is word aligned
    always_comb begin
        if (exception_pending)
            redirect_vaddr = {exception_vaddr, 1'b0};
        else
            redirect_vaddr = eff_addr[`XLEN-1:1];  // Branch target a+b
    end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
// Module execute_stage: top level joining the interrupt, exception, memory and writeback units
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module execute_stage (
    input  logic                     clock,
    input  logic                     rst_n,
    input  exec_pkg::mode_t          current_mode,
    // Decode side
    input  logic                     instruction_addr_misaligned,
    input  logic                     instruction_illegal,
    input  logic                     e_call,
    input  logic                     e_break,
    input  exec_pkg::mem_access_t    memory_access,
    input  exec_pkg::result_select_t result_select,
    input  logic                     save_result_to_gpr,
    input  logic [4:0]               rd_num,
    input  logic                     is_memory_op,
    input  logic                     is_lr,
    input  logic                     is_sc,
    input  logic                     is_signed_memory_op,
    input  logic [`XLEN-1:0]         a,
    input  logic [`XLEN-1:0]         b,
    input  logic                     is_branch,
    input  logic                     branch_taken,
    input  logic                     wait_for_interrupt,
    input  logic                     suppress_interrupts,
    input  logic [`XLEN-1:1]         decode_instruction_vaddr,
    output logic [`XLEN-1:0]         execute_result,
    output logic                     stall,
    output logic                     redirect,
    output logic [`XLEN-1:1]         redirect_vaddr,
    // Register file
    output logic [4:0]               rd,
    output logic [`XLEN-1:0]         rd_value,
    output logic                     rd_write,
    // MMU
    output logic [`VLEN-1:0]         mmu_vaddr,
    output logic                     mmu_access_r,
    output logic                     mmu_access_w,
    input  logic                     mmu_match,
    input  logic                     mmu_fault,
    input  logic                     mmu_fault_dns,
    input  logic [`PLEN-1:0]         mmu_paddr,
    // Memory
    output logic                     mem_cycle,
    output logic [`PLEN-1:0]         mem_paddr,
    output exec_pkg::mem_access_t    mem_access,
    output logic [`XLEN-1:0]         mem_data_out,
    input  logic [`XLEN-1:0]         mem_data_in,
    input  logic                     mem_ack,
    // Interrupt controller
    input  logic                     m_eie,
    input  logic                     m_tie,
    input  logic                     s_eie,
    input  logic                     s_tie,
    input  logic                     m_timer,
    input  logic                     s_timer,
    input  logic                     m_interrupt,
    input  logic                     s_interrupt,
    // Internal registers and trap handling
    input  logic [`XLEN-1:0]         ireg_out,
    output logic                     exception_pending,
    output logic                     interrupt_exception,
    output exec_pkg::exc_code_t      exception_code,
    input  logic [`XLEN-1:2]         exception_vaddr
);

    logic m_timer_c, s_timer_c, m_int_c, s_int_c, wake;
    logic load_misaligned, store_misaligned, load_page_fault, store_page_fault;
    logic tlb_miss, store_access, mem_done, reserved;
    logic [`XLEN-1:0] eff_addr;
    logic [`XLEN-1:0] memory_result;

    interrupt_gate u_interrupt_gate (
        .clock, .rst_n, .stall, .suppress_interrupts,
        .m_tie, .s_tie, .m_eie, .s_eie,
        .m_timer, .s_timer, .m_interrupt, .s_interrupt, .current_mode,
        .m_timer_c, .s_timer_c, .m_int_c, .s_int_c, .wake
    );

    exception_priority u_exception_priority (
        .instruction_addr_misaligned, .instruction_illegal, .e_call, .e_break,
        .m_timer_c, .s_timer_c, .m_int_c, .s_int_c,
        .load_misaligned, .store_misaligned, .load_page_fault, .store_page_fault,
        .tlb_miss, .store_access, .mmu_fault_dns, .current_mode,
        .exception_pending, .interrupt_exception, .exception_code
    );

    memory_access_unit u_memory_access_unit (
        .clock, .rst_n, .a, .b, .mem_data_in, .memory_access,
        .is_memory_op, .is_lr, .is_sc, .is_signed_memory_op, .exception_pending,
        .mmu_match, .mmu_fault, .mem_ack, .mmu_paddr,
        .eff_addr, .memory_result, .mem_data_out, .mmu_vaddr,
        .mmu_access_r, .mmu_access_w, .store_access, .mem_cycle, .mem_done, .reserved,
        .load_misaligned, .store_misaligned, .load_page_fault, .store_page_fault,
        .tlb_miss, .mem_paddr, .mem_access
    );

    writeback_redirect u_writeback_redirect (
        .result_select, .eff_addr, .memory_result, .ireg_out,
        .decode_instruction_vaddr, .exception_vaddr,
        .reserved, .mem_done, .is_memory_op, .wait_for_interrupt, .wake,
        .save_result_to_gpr, .exception_pending, .is_branch, .branch_taken, .rd_num,
        .execute_result, .rd_value, .rd, .rd_write, .stall, .redirect, .redirect_vaddr
    );

endmodule

`default_nettype wire

// ==== tb/exec_checks.svh ====
// Compare tasks for the execute stage testbench: bits, data, addresses, register numbers, codes
`ifndef EXEC_CHECKS_SVH
`define EXEC_CHECKS_SVH

// Single-bit outputs such as stall and rd_write
task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %b, expected %b (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

// Full-width results
task automatic check_data(input string name, input logic [`XLEN-1:0] got,
                          input logic [`XLEN-1:0] expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %h, expected %h (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

// Halfword-aligned target, shown as a byte address
task automatic check_vaddr(input string name, input logic [`XLEN-1:1] got,
                           input logic [`XLEN-1:1] expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %h, expected %h (vector %0d)",
                 $time, name, {got, 1'b0}, {expected, 1'b0}, vector_index);
        end_with_failure();
    end
endtask

// Virtual address towards the MMU
task automatic check_mmu_vaddr(input string name, input logic [`VLEN-1:0] got,
                               input logic [`VLEN-1:0] expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %h, expected %h (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

// Physical address towards memory
task automatic check_paddr(input string name, input logic [`PLEN-1:0] got,
                           input logic [`PLEN-1:0] expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %h, expected %h (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

// Destination register number
task automatic check_reg_num(input string name, input logic [4:0] got,
                             input logic [4:0] expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %0d, expected %0d (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

// Size and direction handed to memory
task automatic check_access(input string name, input exec_pkg::mem_access_t got,
                            input exec_pkg::mem_access_t expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %0d, expected %0d (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

task automatic check_code(input string name, input exec_pkg::exc_code_t got,
                          input exec_pkg::exc_code_t expected);
    if (got !== expected) begin
        $display("ERROR at %0d ns: %s is %0d, expected %0d (vector %0d)",
                 $time, name, got, expected, vector_index);
        end_with_failure();
    end
endtask

`endif

// ==== tb/execute_stage_tb.sv ====
// Testbench execute_stage_tb: clock, reset, golden-file vectors, timeout and verdict
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module execute_stage_tb;
    import exec_pkg::*;

    localparam int half_period  = 4;     // 8 ns clock
    localparam int reset_cycles = 16;
    localparam logic [`XLEN-1:0] trap_vector = 64'h100;

    // DUT inputs
    logic                     clock, rst_n;
    mode_t                    current_mode;
    logic                     instruction_addr_misaligned, instruction_illegal;
    logic                     e_call, e_break;
    mem_access_t              memory_access;
    result_select_t           result_select;
    logic                     save_result_to_gpr;
    logic [4:0]               rd_num;
    logic                     is_memory_op, is_lr, is_sc, is_signed_memory_op;
    logic [`XLEN-1:0]         a, b;
    logic                     is_branch, branch_taken, wait_for_interrupt;
    logic                     suppress_interrupts;
    logic [`XLEN-1:1]         decode_instruction_vaddr;
    logic                     mmu_match, mmu_fault, mmu_fault_dns;
    logic [`PLEN-1:0]         mmu_paddr;
    logic [`XLEN-1:0]         mem_data_in;
    logic                     mem_ack;
    logic                     m_eie, m_tie, s_eie, s_tie;
    logic                     m_timer, s_timer, m_interrupt, s_interrupt;
    logic [`XLEN-1:0]         ireg_out;
    logic [`XLEN-1:2]         exception_vaddr;

    // DUT outputs
    logic [`XLEN-1:0]         execute_result, rd_value, mem_data_out;
    logic                     stall, redirect, rd_write;
    logic [`XLEN-1:1]         redirect_vaddr;
    logic [4:0]               rd;
    logic [`VLEN-1:0]         mmu_vaddr;
    logic                     mmu_access_r, mmu_access_w, mem_cycle;
    logic [`PLEN-1:0]         mem_paddr;
    mem_access_t              mem_access;
    logic                     exception_pending, interrupt_exception;
    exc_code_t                exception_code;

    string golden_lines[$];   // Data lines only, comments dropped
    int    vector_index = 0;
    int    cycle_count  = 0;
    int    cycle_limit  = 0;  // Set once the file is loaded

    execute_stage DUT (.*);

    `include "exec_checks.svh"

    task automatic end_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic load_golden();
        int    fd;
        string text;
        fd = $fopen("tb/exec_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file tb/exec_golden.txt");
            end_with_failure();
        end
        while ($fgets(text, fd) > 0) begin
            if (text.len() > 1 && text[0] != "#")  // Skip comments and blank lines
                golden_lines.push_back(text);
        end
        $fclose(fd);
    endtask

    // Quiet stage, MMU hits, no interrupt lines
    task automatic drive_idle();
        current_mode = M;
        {instruction_addr_misaligned, instruction_illegal, e_call, e_break} = 4'b0;
        memory_access = NONE;
        result_select = ADD;
        save_result_to_gpr = 1'b0;
        rd_num = 5'd0;
        {is_memory_op, is_lr, is_sc, is_signed_memory_op} = 4'b0;
        a = '0;
        b = '0;
        {is_branch, branch_taken, wait_for_interrupt, suppress_interrupts} = 4'b0;
        decode_instruction_vaddr = '0;
        {mmu_match, mmu_fault, mmu_fault_dns} = 3'b100;
        mem_data_in = '0;
        mem_ack = 1'b0;
        {m_eie, m_tie, s_eie, s_tie} = 4'b0;
        {m_timer, s_timer, m_interrupt, s_interrupt} = 4'b0;
    endtask

    // Drive one line on the falling edge, compare just before the rising edge
    task automatic run_vector(input string text);
        int               fields, mode_v, acc_v, sel_v, rd_v, code_v;
        logic [11:0]      flags;
        logic [2:0]       mmu_v;
        logic [8:0]       irq_v;
        logic [`XLEN-1:0] a_v, b_v, pc_v, din_v, val_v, rv_v, sum_v;
        logic             ack_v, wr_v, stall_v, cyc_v, redir_v, pend_v, int_v;
        fields = $sscanf(text,
            "%d %b %d %d %d %h %h %h %b %b %h %b %b %h %b %b %b %h %b %b %d",
            mode_v, flags, acc_v, sel_v, rd_v, a_v, b_v, pc_v, mmu_v, ack_v, din_v, irq_v,
            wr_v, val_v, stall_v, cyc_v, redir_v, rv_v, pend_v, int_v, code_v);
        if (fields != 21) begin
            $display("Golden line %0d has %0d fields instead of 21", vector_index, fields);
            end_with_failure();
        end
        current_mode  = mode_t'(mode_v[1:0]);
        memory_access = mem_access_t'(acc_v[3:0]);
        result_select = result_select_t'(sel_v[2:0]);
        rd_num        = rd_v[4:0];
        {is_memory_op, is_lr, is_sc, is_signed_memory_op} = flags[11:8];
        {save_result_to_gpr, is_branch, branch_taken, wait_for_interrupt} = flags[7:4];
        {e_call, e_break, instruction_illegal, instruction_addr_misaligned} = flags[3:0];
        a = a_v;
        b = b_v;
        decode_instruction_vaddr = pc_v[`XLEN-1:1];
        {mmu_match, mmu_fault, mmu_fault_dns} = mmu_v;
        mem_ack     = ack_v;
        mem_data_in = din_v;
        suppress_interrupts = irq_v[8];
        {m_tie, s_tie, m_eie, s_eie} = irq_v[7:4];
        {m_timer, s_timer, m_interrupt, s_interrupt} = irq_v[3:0];
        sum_v = a_v + b_v;  // Effective address
        #(half_period - 1);
        check_bit("rd_write", rd_write, wr_v);
        if (wr_v) begin
            check_data("rd_value", rd_value, val_v);  // Only meaningful on a write
            check_data("execute_result", execute_result, val_v);
            check_reg_num("rd", rd, rd_v[4:0]);
        end
        check_bit("stall", stall, stall_v);
        check_bit("mem_cycle", mem_cycle, cyc_v);
        check_bit("redirect", redirect, redir_v);
        if (redir_v)
            check_vaddr("redirect_vaddr", redirect_vaddr, rv_v[`XLEN-1:1]);
        check_bit("exception_pending", exception_pending, pend_v);
        check_bit("interrupt_exception", interrupt_exception, int_v);
        if (pend_v)
            check_code("exception_code", exception_code, exc_code_t'(code_v[`EXC_W-1:0]));
        // MMU and memory side, read kinds 1 to 4, write kinds 5 to 8
        check_mmu_vaddr("mmu_vaddr", mmu_vaddr, sum_v[`VLEN-1:0]);
        check_bit("mmu_access_r", mmu_access_r, acc_v >= 1 && acc_v <= 4);
        check_bit("mmu_access_w", mmu_access_w, acc_v >= 5 && acc_v <= 8);
        check_access("mem_access", mem_access, mem_access_t'(acc_v[3:0]));
        check_paddr("mem_paddr", mem_paddr, mmu_paddr);
        check_data("mem_data_out", mem_data_out, b_v);  // Store data is b
    endtask

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // Watchdog on clock cycles
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            end_with_failure();
        end
    end

    initial begin
        rst_n = 1'b0;
        drive_idle();
        mmu_paddr       = 56'h1000;  // Physical side not under test
        ireg_out        = '0;
        exception_vaddr = trap_vector[`XLEN-1:2];
        load_golden();
        cycle_limit = reset_cycles + golden_lines.size() + 20;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;  // One idle cycle before the first vector
        for (vector_index = 0; vector_index < golden_lines.size(); vector_index++) begin
            @(negedge clock);
            run_vector(golden_lines[vector_index]);
        end
        if (golden_lines.size() > 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("The golden file holds no test vectors");
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
+incdir+tb
source/exec_pkg.sv
source/interrupt_gate.sv
source/exception_priority.sv
source/memory_access_unit.sv
source/writeback_redirect.sv
source/execute_stage.sv
tb/execute_stage_tb.sv

// ==== tb/exec_golden.txt ====
# md flags acc sel rd a b pc mmu ack din irq, then expected: wr rd_value stall cyc redir
# redir_addr pend int code. flags: mem lr sc signed save br taken wfi ecall ebreak ill imis
# mmu: match fault dns. irq: sup mtie stie meie seie mtimer stimer mint sint. Values in hex
3 100110000000 1 2 5 1000 3 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 100110000000 1 2 5 1000 3 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 100110000000 1 2 5 1000 3 0 100 1 80 000000000  1 ffffffffffffff80 0 1 0 0 0 0 0
3 100010000000 2 2 6 2000 2 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 100010000000 2 2 6 2000 2 0 100 1 ffff8001 000000000  1 8001 0 1 0 0 0 0 0
3 100000000000 7 0 0 3000 2 0 100 0 0 000000000  0 0 0 0 1 100 1 0 6
3 100000000000 8 0 0 3000 8 0 000 0 0 000000000  0 0 0 0 1 100 1 0 25
3 100010000000 3 2 7 8000000000 0 0 100 0 0 000000000  0 0 0 0 1 100 1 0 13
3 110010000000 4 2 8 4000 0 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 110010000000 4 2 8 4000 0 0 100 1 1234 000000000  1 1234 0 1 0 0 0 0 0
3 101010000000 8 1 9 4000 0 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 101010000000 8 1 9 4000 0 0 100 1 0 000000000  1 0 0 1 0 0 0 0 0
3 101010000000 8 1 9 4000 0 0 100 0 0 000000000  1 1 0 0 0 0 0 0 0
1 000010000000 0 0 10 10 20 0 100 0 0 010001000  0 0 0 0 1 100 1 1 7
3 000010000000 0 0 10 10 20 0 100 0 0 000010001  1 30 0 0 0 0 0 0 0
3 000010000000 0 0 10 10 20 0 100 0 0 110001000  1 30 0 0 0 0 0 0 0
3 100010000000 1 2 11 5000 0 0 100 0 0 000000000  1 0 1 1 0 0 0 0 0
3 100010000000 1 2 11 5000 0 0 100 0 0 000100010  1 0 1 1 0 0 0 0 0
3 100010000000 1 2 11 5000 0 0 100 1 42 000100010  1 42 0 1 0 0 0 0 0
3 000010000000 0 0 12 1 1 0 100 0 0 000100010  0 0 0 0 1 100 1 1 11
3 000001100000 0 0 0 6000 24 0 100 0 0 000000000  0 0 0 0 1 6024 0 0 0
1 100010001000 3 2 0 7000 0 0 110 0 0 000000000  0 0 0 0 1 100 1 0 9
3 000000010000 0 0 0 0 0 0 100 0 0 000000000  0 0 1 0 0 0 0 0 0
3 000000010000 0 0 0 0 0 0 100 0 0 000000000  0 0 1 0 0 0 0 0 0
3 000000010000 0 0 0 0 0 0 100 0 0 000000100  0 0 0 0 0 0 0 0 0
3 000010000000 0 0 13 100 23 0 100 0 0 000000000  1 123 0 0 0 0 0 0 0
3 000010000000 0 4 1 0 0 8004 100 0 0 000000000  1 8004 0 0 0 0 0 0 0
